// ==== decode_unit.f ====
logic/rv_decode_pkg.sv
logic/decode_ctrl_if.sv
logic/fetch_latch.sv
logic/inst_classifier.sv
logic/imm_gen.sv
logic/issue_register.sv
logic/decode_unit.sv
tests/decode_unit_asserts.sv
tests/decode_checker.sv
tests/decode_unit_tb.sv

// ==== logic/decode_ctrl_if.sv ====
`timescale 1ns/1ps

interface decode_ctrl_if;
  import rv_decode_pkg::*;

  alu_op_t    alu_op;
  logic       op2_imm;
  logic       op1_zero;
  logic       reg_wen;
  logic       mem_ren;
  logic       mem_wen;
  logic       size_b;
  logic       size_h;
  logic       sext;
  npc_sel_t   npc_sel;
  wdata_sel_t wdata_sel;
  logic       illegal;
  logic       uses_rs1;
  logic       uses_rs2;

  modport source (
    output alu_op, op2_imm, op1_zero, reg_wen, mem_ren, mem_wen,
           size_b, size_h, sext, npc_sel, wdata_sel, illegal, uses_rs1, uses_rs2
  );

  modport sink (
    input alu_op, op2_imm, op1_zero, reg_wen, mem_ren, mem_wen,
          size_b, size_h, sext, npc_sel, wdata_sel, illegal, uses_rs1, uses_rs2
  );

endinterface

// ==== logic/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 inst_valid,
  input  logic [rv_decode_pkg::XLEN-1:0]       inst,
  input  logic [rv_decode_pkg::XLEN-1:0]       pc,
  input  logic                                 block,
  input  logic                                 flush,
  output logic                                 ready,
  output logic                                 out_valid,
  output logic [rv_decode_pkg::XLEN-1:0]       out_pc,
  output rv_decode_pkg::alu_op_t               out_alu_op,
  output logic [rv_decode_pkg::XLEN-1:0]       out_imm,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] out_rs1,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] out_rs2,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] out_rd,
  output logic                                 out_reg_wen,
  output logic                                 out_mem_ren,
  output logic                                 out_mem_wen,
  output logic                                 out_size_b,
  output logic                                 out_size_h,
  output logic                                 out_sext,
  output rv_decode_pkg::npc_sel_t              out_npc_sel,
  output rv_decode_pkg::wdata_sel_t            out_wdata_sel,
  output logic                                 out_illegal,
  output rv_decode_pkg::fwd_sel_t              fwd1_sel,
  output rv_decode_pkg::fwd_sel_t              fwd2_sel
);
  import rv_decode_pkg::*;

  logic            lat_valid;
  logic [XLEN-1:0] lat_inst;
  logic [XLEN-1:0] lat_pc;
  logic [XLEN-1:0] imm;

  decode_ctrl_if ctrl_if ();

  fetch_latch fetch_latch_i (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .block      (block),
    .flush      (flush),
    .ready      (ready),
    .lat_valid  (lat_valid),
    .lat_inst   (lat_inst),
    .lat_pc     (lat_pc)
  );

  // classifier and immediate both work on the latched word
  inst_classifier inst_classifier_i (
    .lat_inst (lat_inst),
    .ctrl     (ctrl_if.source)
  );

  imm_gen imm_gen_i (
    .lat_inst (lat_inst),
    .imm      (imm)
  );

  issue_register issue_register_i (
    .clock         (clock),
    .reset         (reset),
    .block         (block),
    .flush         (flush),
    .lat_valid     (lat_valid),
    .lat_inst      (lat_inst),
    .lat_pc        (lat_pc),
    .imm           (imm),
    .ctrl          (ctrl_if.sink),
    .out_valid     (out_valid),
    .out_pc        (out_pc),
    .out_alu_op    (out_alu_op),
    .out_imm       (out_imm),
    .out_rs1       (out_rs1),
    .out_rs2       (out_rs2),
    .out_rd        (out_rd),
    .out_reg_wen   (out_reg_wen),
    .out_mem_ren   (out_mem_ren),
    .out_mem_wen   (out_mem_wen),
    .out_size_b    (out_size_b),
    .out_size_h    (out_size_h),
    .out_sext      (out_sext),
    .out_npc_sel   (out_npc_sel),
    .out_wdata_sel (out_wdata_sel),
    .out_illegal   (out_illegal),
    .fwd1_sel      (fwd1_sel),
    .fwd2_sel      (fwd2_sel)
  );

endmodule

// ==== logic/fetch_latch.sv ====
`timescale 1ns/1ps

module fetch_latch (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           inst_valid,
  input  logic [rv_decode_pkg::XLEN-1:0] inst,
  input  logic [rv_decode_pkg::XLEN-1:0] pc,
  input  logic                           block,
  input  logic                           flush,
  output logic                           ready,
  output logic                           lat_valid,
  output logic [rv_decode_pkg::XLEN-1:0] lat_inst,
  output logic [rv_decode_pkg::XLEN-1:0] lat_pc
);
  import rv_decode_pkg::*;

  logic [REG_ADDR_W-1:0] lat_rd;
  logic [REG_ADDR_W-1:0] in_rs1;
  logic [REG_ADDR_W-1:0] in_rs2;
  logic                  lat_load;
  logic                  accept;

  assign lat_rd = lat_inst[RD_LSB +: REG_ADDR_W];

  // raw source fields of the incoming word, whatever its format
  assign in_rs1 = inst[RS1_LSB +: REG_ADDR_W];
  assign in_rs2 = inst[RS2_LSB +: REG_ADDR_W];

  // latched load that writes a real register
  assign lat_load = lat_valid && (opcode_t'(lat_inst[OPCODE_W-1:0]) == opc_load) &&
                    (lat_rd != '0);

  // hold the consumer until the load has moved on to issue
  assign ready = !(lat_load && ((in_rs1 == lat_rd) || (in_rs2 == lat_rd)));

  assign accept = inst_valid && ready && !block && !flush;

  always_ff @(posedge clock) begin
    if (reset) begin
      lat_valid <= 1'b0;
      lat_inst <= '0;
    end else if (!block) begin
      if (accept) begin
        lat_valid <= 1'b1;
        lat_inst <= inst;
      end else begin
        // empty slot, downstream sees a bubble
        lat_valid <= 1'b0;
        lat_inst <= '0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      lat_pc <= pc;
    end
  end

endmodule

// ==== logic/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
  input  logic [rv_decode_pkg::XLEN-1:0] lat_inst,
  output logic [rv_decode_pkg::XLEN-1:0] imm
);
  import rv_decode_pkg::*;

  opcode_t opcode;
  logic    sign;

  assign opcode = opcode_t'(lat_inst[OPCODE_W-1:0]);
  assign sign = lat_inst[XLEN-1];

  always_comb begin
    case (opcode)
      // U format, upper 20 bits
      opc_lui, opc_auipc: imm = {lat_inst[31:12], 12'b0};
      // J format, halfword aligned offset
      opc_jal: imm = {{12{sign}}, lat_inst[19:12], lat_inst[20], lat_inst[30:21], 1'b0};
      opc_branch: imm = {{20{sign}}, lat_inst[7], lat_inst[30:25], lat_inst[11:8], 1'b0};
      opc_jalr, opc_load, opc_op_imm: imm = {{20{sign}}, lat_inst[31:20]};
      opc_store: imm = {{20{sign}}, lat_inst[31:25], lat_inst[11:7]};
      // R format and unknown opcodes
      default: imm = '0;
    endcase
  end

endmodule

// ==== logic/inst_classifier.sv ====
`timescale 1ns/1ps

module inst_classifier (
  input  logic [rv_decode_pkg::XLEN-1:0] lat_inst,
  decode_ctrl_if.source                  ctrl
);
  import rv_decode_pkg::*;

  opcode_t             opcode;
  logic [FUNCT3_W-1:0] funct3;
  logic [FUNCT7_W-1:0] funct7;
  logic                legal;

  assign opcode = opcode_t'(lat_inst[OPCODE_W-1:0]);
  assign funct3 = lat_inst[FUNCT3_LSB +: FUNCT3_W];
  assign funct7 = lat_inst[FUNCT7_LSB +: FUNCT7_W];

  // register and immediate arithmetic share the funct3 map
  function automatic alu_op_t arith_op(input logic [FUNCT3_W-1:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  // only base integer encodings pass
  always_comb begin
    case (opcode)
      opc_lui, opc_auipc, opc_jal: legal = 1'b1;
      opc_jalr:   legal = (funct3 == 3'b000);
      opc_branch: legal = (funct3 != 3'b010) && (funct3 != 3'b011);
      opc_load:   legal = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
      opc_store:  legal = (funct3 inside {3'b000, 3'b001, 3'b010});
      opc_op_imm: begin
        if (funct3 == 3'b001) legal = (funct7 == F7_BASE);
        else if (funct3 == 3'b101) legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
        else legal = 1'b1;
      end
      opc_op: legal = (funct7 == F7_BASE) ||
                      ((funct7 == F7_ALT) && (funct3 inside {3'b000, 3'b101}));
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    ctrl.alu_op = alu_add;
    ctrl.op2_imm = 1'b0;
    ctrl.op1_zero = 1'b0;
    ctrl.reg_wen = 1'b0;
    ctrl.mem_ren = 1'b0;
    ctrl.mem_wen = 1'b0;
    ctrl.size_b = 1'b0;
    ctrl.size_h = 1'b0;
    ctrl.sext = 1'b0;
    ctrl.npc_sel = npc_seq;
    ctrl.wdata_sel = wdata_alu;
    ctrl.illegal = !legal;
    ctrl.uses_rs1 = 1'b0;
    ctrl.uses_rs2 = 1'b0;
    if (legal) begin
      case (opcode)
        opc_lui: begin
          // x0 + imm through the adder
          ctrl.op1_zero = 1'b1;
          ctrl.op2_imm = 1'b1;
          ctrl.reg_wen = 1'b1;
        end
        opc_auipc: begin
          ctrl.reg_wen = 1'b1;
          ctrl.wdata_sel = wdata_pc_plus_imm;
        end
        opc_jal: begin
          ctrl.reg_wen = 1'b1;
          ctrl.npc_sel = npc_jal;
          ctrl.wdata_sel = wdata_pc_plus4;
        end
        opc_jalr: begin
          ctrl.op2_imm = 1'b1;
          ctrl.reg_wen = 1'b1;
          ctrl.npc_sel = npc_jalr;
          ctrl.wdata_sel = wdata_pc_plus4;
          ctrl.uses_rs1 = 1'b1;
        end
        opc_branch: begin
          case (funct3)
            3'b000:  ctrl.alu_op = alu_beq;
            3'b001:  ctrl.alu_op = alu_bne;
            3'b100:  ctrl.alu_op = alu_blt;
            3'b101:  ctrl.alu_op = alu_bge;
            3'b110:  ctrl.alu_op = alu_bltu;
            default: ctrl.alu_op = alu_bgeu;
          endcase
          ctrl.npc_sel = npc_branch;
          ctrl.uses_rs1 = 1'b1;
          ctrl.uses_rs2 = 1'b1;
        end
        opc_load: begin
          ctrl.op2_imm = 1'b1;
          ctrl.reg_wen = 1'b1;
          ctrl.mem_ren = 1'b1;
          ctrl.size_b = (funct3 == 3'b000) || (funct3 == 3'b100);
          ctrl.size_h = (funct3 == 3'b001) || (funct3 == 3'b101);
          // lb and lh sign extend, lbu and lhu do not
          ctrl.sext = (funct3 == 3'b000) || (funct3 == 3'b001);
          ctrl.uses_rs1 = 1'b1;
        end
        opc_store: begin
          ctrl.op2_imm = 1'b1;
          ctrl.mem_wen = 1'b1;
          ctrl.size_b = (funct3 == 3'b000);
          ctrl.size_h = (funct3 == 3'b001);
          ctrl.uses_rs1 = 1'b1;
          ctrl.uses_rs2 = 1'b1;
        end
        opc_op_imm: begin
          // no subi, so alt only matters for the shift
          ctrl.alu_op = arith_op(funct3, (funct3 == 3'b101) && (funct7 == F7_ALT));
          ctrl.op2_imm = 1'b1;
          ctrl.reg_wen = 1'b1;
          ctrl.uses_rs1 = 1'b1;
        end
        default: begin
          ctrl.alu_op = arith_op(funct3, funct7 == F7_ALT);
          ctrl.reg_wen = 1'b1;
          ctrl.uses_rs1 = 1'b1;
          ctrl.uses_rs2 = 1'b1;
        end
      endcase
    end
  end

endmodule

// ==== logic/issue_register.sv ====
`timescale 1ns/1ps

module issue_register (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 block,
  input  logic                                 flush,
  input  logic                                 lat_valid,
  input  logic [rv_decode_pkg::XLEN-1:0]       lat_inst,
  input  logic [rv_decode_pkg::XLEN-1:0]       lat_pc,
  input  logic [rv_decode_pkg::XLEN-1:0]       imm,
  decode_ctrl_if.sink                          ctrl,
  output logic                                 out_valid,
  output logic [rv_decode_pkg::XLEN-1:0]       out_pc,
  output rv_decode_pkg::alu_op_t               out_alu_op,
  output logic [rv_decode_pkg::XLEN-1:0]       out_imm,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] out_rs1,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] out_rs2,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] out_rd,
  output logic                                 out_reg_wen,
  output logic                                 out_mem_ren,
  output logic                                 out_mem_wen,
  output logic                                 out_size_b,
  output logic                                 out_size_h,
  output logic                                 out_sext,
  output rv_decode_pkg::npc_sel_t              out_npc_sel,
  output rv_decode_pkg::wdata_sel_t            out_wdata_sel,
  output logic                                 out_illegal,
  output rv_decode_pkg::fwd_sel_t              fwd1_sel,
  output rv_decode_pkg::fwd_sel_t              fwd2_sel
);
  import rv_decode_pkg::*;

  logic                  issue;
  logic [REG_ADDR_W-1:0] next_rs1;
  logic [REG_ADDR_W-1:0] next_rs2;
  logic [REG_ADDR_W-1:0] next_rd;
  logic [REG_ADDR_W-1:0] rd_hist2;
  fwd_sel_t              next_fwd1;
  fwd_sel_t              next_fwd2;

  // nearest producer wins, x0 is never forwarded
  function automatic fwd_sel_t pick_fwd(input logic used,
                                        input logic [REG_ADDR_W-1:0] rs,
                                        input logic [REG_ADDR_W-1:0] rd1,
                                        input logic [REG_ADDR_W-1:0] rd2);
    if (!used || (rs == '0)) return fwd_regfile;
    if (rs == rd1) return fwd_from_issue1;
    if (rs == rd2) return fwd_from_issue2;
    return fwd_regfile;
  endfunction

  // a flushed or empty latch goes out as a bubble
  assign issue = lat_valid && !flush;

  assign next_rs1 = ctrl.op1_zero ? '0 : lat_inst[RS1_LSB +: REG_ADDR_W];
  // immediate takes the rs2 slot unless store data still needs it
  assign next_rs2 = (ctrl.op2_imm && !ctrl.uses_rs2) ? '0 : lat_inst[RS2_LSB +: REG_ADDR_W];
  assign next_rd = (issue && ctrl.reg_wen) ? lat_inst[RD_LSB +: REG_ADDR_W] : '0;

  // out_rd is the instruction one ahead, rd_hist2 the one before it
  assign next_fwd1 = pick_fwd(issue && ctrl.uses_rs1, next_rs1, out_rd, rd_hist2);
  assign next_fwd2 = pick_fwd(issue && ctrl.uses_rs2, next_rs2, out_rd, rd_hist2);

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_reg_wen <= 1'b0;
      out_mem_ren <= 1'b0;
      out_mem_wen <= 1'b0;
      out_rd <= '0;
      rd_hist2 <= '0;
    end else if (!block) begin
      out_valid <= issue;
      out_reg_wen <= issue && ctrl.reg_wen;
      out_mem_ren <= issue && ctrl.mem_ren;
      out_mem_wen <= issue && ctrl.mem_wen;
      out_rd <= next_rd;
      rd_hist2 <= out_rd;
    end
  end

  always_ff @(posedge clock) begin
    if (!block) begin
      out_pc <= lat_pc;
      out_alu_op <= issue ? ctrl.alu_op : alu_add;
      out_imm <= (issue && !ctrl.illegal) ? imm : '0;
      out_rs1 <= issue ? next_rs1 : '0;
      out_rs2 <= issue ? next_rs2 : '0;
      out_size_b <= issue && ctrl.size_b;
      out_size_h <= issue && ctrl.size_h;
      out_sext <= issue && ctrl.sext;
      out_npc_sel <= issue ? ctrl.npc_sel : npc_seq;
      out_wdata_sel <= issue ? ctrl.wdata_sel : wdata_alu;
      out_illegal <= issue && ctrl.illegal;
      fwd1_sel <= next_fwd1;
      fwd2_sel <= next_fwd2;
    end
  end

endmodule

// ==== logic/rv_decode_pkg.sv ====
package rv_decode_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  // instruction field positions
  localparam int OPCODE_W = 7;
  localparam int RD_LSB = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int FUNCT3_W = 3;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int FUNCT7_LSB = 25;
  localparam int FUNCT7_W = 7;

  // funct7 patterns of the base set; alt selects sub and sra
  localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
  localparam logic [FUNCT7_W-1:0] F7_ALT = 7'b0100000;

  typedef enum logic [OPCODE_W-1:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_t;

  // compare ops share the encoding space so one field covers both
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt,
    alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_beq, alu_bne,
    alu_blt, alu_bge, alu_bltu, alu_bgeu
  } alu_op_t;

  typedef enum logic [1:0] {
    npc_seq    = 2'b00,
    npc_jal    = 2'b01,
    npc_jalr   = 2'b10,
    npc_branch = 2'b11
  } npc_sel_t;

  typedef enum logic [1:0] {
    wdata_alu         = 2'b00,
    wdata_pc_plus4    = 2'b01,
    wdata_pc_plus_imm = 2'b10
  } wdata_sel_t;

  typedef enum logic [1:0] {
    fwd_regfile     = 2'b00,
    fwd_from_issue1 = 2'b01,
    fwd_from_issue2 = 2'b10
  } fwd_sel_t;

endpackage

// ==== tests/decode_checker.sv ====
`timescale 1ns/1ps

module decode_checker (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 inst_valid,
  input  logic [rv_decode_pkg::XLEN-1:0]       inst,
  input  logic [rv_decode_pkg::XLEN-1:0]       pc,
  input  logic                                 block,
  input  logic                                 flush,
  input  logic                                 ready,
  input  logic                                 out_valid,
  input  logic [rv_decode_pkg::XLEN-1:0]       out_pc,
  input  rv_decode_pkg::alu_op_t               out_alu_op,
  input  logic [rv_decode_pkg::XLEN-1:0]       out_imm,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] out_rs1,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] out_rs2,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] out_rd,
  input  logic                                 out_reg_wen,
  input  logic                                 out_mem_ren,
  input  logic                                 out_mem_wen,
  input  logic                                 out_size_b,
  input  logic                                 out_size_h,
  input  logic                                 out_sext,
  input  rv_decode_pkg::npc_sel_t              out_npc_sel,
  input  rv_decode_pkg::wdata_sel_t            out_wdata_sel,
  input  logic                                 out_illegal,
  input  rv_decode_pkg::fwd_sel_t              fwd1_sel,
  input  rv_decode_pkg::fwd_sel_t              fwd2_sel,
  output int                                   error_count,
  output int                                   check_count,
  output logic                                 idle
);
  import rv_decode_pkg::*;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    alu_op_t               alu_op;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_wen;
    logic                  mem_ren;
    logic                  mem_wen;
    logic                  size_b;
    logic                  size_h;
    logic                  sext;
    npc_sel_t              npc_sel;
    wdata_sel_t            wdata_sel;
    logic                  illegal;
    fwd_sel_t              fwd1;
    fwd_sel_t              fwd2;
  } issue_word_t;

  // funct3 order of the base arithmetic and branch groups
  localparam alu_op_t ARITH_OPS [8] = '{alu_add, alu_sll, alu_slt, alu_sltu,
                                        alu_xor, alu_srl, alu_or, alu_and};
  localparam alu_op_t BRANCH_OPS [8] = '{alu_beq, alu_bne, alu_add, alu_add,
                                         alu_blt, alu_bge, alu_bltu, alu_bgeu};

  issue_word_t           exp_q[$];
  issue_word_t           lat_word;
  logic [XLEN-1:0]       lat_raw;
  logic [1:0]            lat_uses;
  logic                  lat_full;
  logic [REG_ADDR_W-1:0] hist1;
  logic [REG_ADDR_W-1:0] hist2;
  logic                  fresh;
  int                    errors = 0;
  int                    checks = 0;

  assign error_count = errors;
  assign check_count = checks;

  function automatic logic is_legal(input logic [XLEN-1:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    case (opcode_t'(w[6:0]))
      opc_lui, opc_auipc, opc_jal: return 1'b1;
      opc_jalr:   return f3 == 3'd0;
      opc_branch: return f3[2:1] != 2'b01;
      opc_load:   return !(f3 == 3'd3 || f3 >= 3'd6);
      opc_store:  return f3 <= 3'd2;
      opc_op_imm: begin
        if (f3 == 3'd1) return f7 == 7'h00;
        if (f3 == 3'd5) return f7 == 7'h00 || f7 == 7'h20;
        return 1'b1;
      end
      opc_op: return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      default: return 1'b0;
    endcase
  endfunction

  // bit 1 for rs1, bit 0 for rs2
  function automatic logic [1:0] used_sources(input logic [XLEN-1:0] w);
    if (!is_legal(w)) return 2'b00;
    case (opcode_t'(w[6:0]))
      opc_jalr, opc_load, opc_op_imm: return 2'b10;
      opc_branch, opc_store, opc_op:  return 2'b11;
      default: return 2'b00;
    endcase
  endfunction

  function automatic issue_word_t ref_decode(input logic [XLEN-1:0] w,
                                             input logic [XLEN-1:0] pc_in);
    issue_word_t e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    e = '0;
    f3 = w[14:12];
    f7 = w[31:25];
    e.pc = pc_in;
    e.rs1 = w[19:15];
    e.rs2 = w[24:20];
    e.illegal = !is_legal(w);
    if (!e.illegal) begin
      case (opcode_t'(w[6:0]))
        opc_lui: begin
          e.rs1 = '0;
          e.rs2 = '0;
          e.imm = {w[31:12], 12'h000};
          e.reg_wen = 1'b1;
        end
        opc_auipc: begin
          e.imm = {w[31:12], 12'h000};
          e.reg_wen = 1'b1;
          e.wdata_sel = wdata_pc_plus_imm;
        end
        opc_jal: begin
          e.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
          e.reg_wen = 1'b1;
          e.npc_sel = npc_jal;
          e.wdata_sel = wdata_pc_plus4;
        end
        opc_jalr: begin
          e.rs2 = '0;
          e.imm = 32'($signed(w[31:20]));
          e.reg_wen = 1'b1;
          e.npc_sel = npc_jalr;
          e.wdata_sel = wdata_pc_plus4;
        end
        opc_branch: begin
          e.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
          e.alu_op = BRANCH_OPS[f3];
          e.npc_sel = npc_branch;
        end
        opc_load: begin
          e.rs2 = '0;
          e.imm = 32'($signed(w[31:20]));
          e.reg_wen = 1'b1;
          e.mem_ren = 1'b1;
          e.size_b = f3[1:0] == 2'b00;
          e.size_h = f3[1:0] == 2'b01;
          // only lb and lh extend the sign
          e.sext = !f3[2] && f3[1:0] != 2'b10;
        end
        opc_store: begin
          e.imm = 32'($signed({w[31:25], w[11:7]}));
          e.mem_wen = 1'b1;
          e.size_b = f3 == 3'd0;
          e.size_h = f3 == 3'd1;
        end
        opc_op_imm: begin
          e.rs2 = '0;
          e.imm = 32'($signed(w[31:20]));
          e.reg_wen = 1'b1;
          e.alu_op = (f3 == 3'd5 && f7[5]) ? alu_sra : ARITH_OPS[f3];
        end
        default: begin
          e.reg_wen = 1'b1;
          if (f7[5]) e.alu_op = (f3 == 3'd0) ? alu_sub : alu_sra;
          else e.alu_op = ARITH_OPS[f3];
        end
      endcase
    end
    if (e.reg_wen) e.rd = w[11:7];
    return e;
  endfunction

  function automatic fwd_sel_t expected_source(input logic used,
                                               input logic [REG_ADDR_W-1:0] rs,
                                               input logic [REG_ADDR_W-1:0] near,
                                               input logic [REG_ADDR_W-1:0] far);
    if (used && rs != '0 && rs == near) return fwd_from_issue1;
    if (used && rs != '0 && rs == far) return fwd_from_issue2;
    return fwd_regfile;
  endfunction

  // inputs and outputs are both settled at the falling edge
  always @(negedge clock) begin
    issue_word_t           got;
    issue_word_t           exp;
    logic [REG_ADDR_W-1:0] new_rd;
    logic                  exp_ready;
    got = '{out_pc, out_alu_op, out_imm, out_rs1, out_rs2, out_rd, out_reg_wen,
            out_mem_ren, out_mem_wen, out_size_b, out_size_h, out_sext, out_npc_sel,
            out_wdata_sel, out_illegal, fwd1_sel, fwd2_sel};
    if (fresh && out_valid) begin
      checks++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("error %0t: issue at pc %h with nothing expected", $time, out_pc);
      end else begin
        exp = exp_q.pop_front();
        if (got !== exp) begin
          errors++;
          $display("error %0t: pc %h expected %h got %h", $time, exp.pc, exp, got);
        end
      end
    end else if (fresh && exp_q.size() != 0) begin
      errors++;
      $display("error %0t: pc %h did not issue on time", $time, exp_q[0].pc);
      exp_q.delete();
    end
    if (reset) begin
      exp_q.delete();
      lat_full = 1'b0;
      lat_raw = '0;
      hist1 = '0;
      hist2 = '0;
      fresh = 1'b0;
    end else begin
      // load-use hold on the raw source fields of the incoming word
      exp_ready = !(lat_full && lat_raw[6:0] == opc_load && lat_raw[11:7] != '0 &&
                    (inst[19:15] == lat_raw[11:7] || inst[24:20] == lat_raw[11:7]));
      checks++;
      if (ready !== exp_ready) begin
        errors++;
        $display("error %0t: ready %b expected %b", $time, ready, exp_ready);
      end
      fresh = !block;
      if (!block) begin
        new_rd = '0;
        // a flush turns the latched word into a bubble
        if (lat_full && !flush) begin
          exp = lat_word;
          exp.fwd1 = expected_source(lat_uses[1], exp.rs1, hist1, hist2);
          exp.fwd2 = expected_source(lat_uses[0], exp.rs2, hist1, hist2);
          exp_q.push_back(exp);
          new_rd = exp.rd;
        end
        hist2 = hist1;
        hist1 = new_rd;
        lat_full = inst_valid && exp_ready && !flush;
        if (lat_full) begin
          lat_raw = inst;
          lat_word = ref_decode(inst, pc);
          lat_uses = used_sources(inst);
        end
      end
    end
    idle = !lat_full && exp_q.size() == 0;
  end

endmodule

// ==== tests/decode_unit_asserts.sv ====
`timescale 1ns/1ps

module decode_unit_asserts (
  input logic                                 clock,
  input logic                                 reset,
  input logic                                 block,
  input logic                                 out_valid,
  input logic [rv_decode_pkg::XLEN-1:0]       out_pc,
  input logic [rv_decode_pkg::XLEN-1:0]       out_imm,
  input logic [rv_decode_pkg::REG_ADDR_W-1:0] out_rd,
  input logic                                 out_reg_wen,
  input logic                                 out_mem_ren,
  input logic                                 out_mem_wen,
  input logic                                 out_illegal,
  input rv_decode_pkg::fwd_sel_t              fwd1_sel,
  input rv_decode_pkg::fwd_sel_t              fwd2_sel
);
  import rv_decode_pkg::*;

  int fail_count = 0;

  // a bubble never writes a register or touches memory
  bubble_quiet: assert property (@(posedge clock) disable iff (reset)
    !out_valid |-> !(out_reg_wen || out_mem_ren || out_mem_wen))
    else begin
      fail_count++;
      $error("enable set while out_valid is low");
    end

  // a frozen stage shows the same word on the next edge
  block_holds: assert property (@(posedge clock) disable iff (reset)
    block |=> $stable({out_valid, out_pc, out_imm, out_rd, out_reg_wen, out_mem_ren,
                       out_mem_wen, out_illegal, fwd1_sel, fwd2_sel}))
    else begin
      fail_count++;
      $error("outputs changed under block");
    end

  reset_clears: assert property (@(posedge clock)
    reset |=> !out_valid && !out_reg_wen && !out_mem_ren && !out_mem_wen)
    else begin
      fail_count++;
      $error("out_valid or an enable high after reset");
    end

  illegal_quiet: assert property (@(posedge clock) disable iff (reset)
    out_valid && out_illegal |-> !(out_reg_wen || out_mem_ren || out_mem_wen))
    else begin
      fail_count++;
      $error("illegal word issued with an enable set");
    end

endmodule

// ==== tests/decode_unit_tb.sv ====
`timescale 1ns/1ps

module decode_unit_tb;
  import rv_decode_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_INST = 400;
  // four cycles per instruction leaves room for stalls, blocks and flushes
  localparam int WATCHDOG_NS = (NUM_INST * 4 + 100) * CLK_PERIOD;
  localparam logic [2:0] LOAD_F3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

  logic                  clock;
  logic                  reset;
  logic                  inst_valid;
  logic [XLEN-1:0]       inst;
  logic [XLEN-1:0]       pc;
  logic                  block;
  logic                  flush;
  logic                  ready;
  logic                  out_valid;
  logic [XLEN-1:0]       out_pc;
  alu_op_t               out_alu_op;
  logic [XLEN-1:0]       out_imm;
  logic [REG_ADDR_W-1:0] out_rs1;
  logic [REG_ADDR_W-1:0] out_rs2;
  logic [REG_ADDR_W-1:0] out_rd;
  logic                  out_reg_wen;
  logic                  out_mem_ren;
  logic                  out_mem_wen;
  logic                  out_size_b;
  logic                  out_size_h;
  logic                  out_sext;
  npc_sel_t              out_npc_sel;
  wdata_sel_t            out_wdata_sel;
  logic                  out_illegal;
  fwd_sel_t              fwd1_sel;
  fwd_sel_t              fwd2_sel;
  int                    error_count;
  int                    check_count;
  logic                  idle;

  logic                  taken;
  logic [31:0]           lcg_state;
  logic [31:0]           r;
  logic [XLEN-1:0]       cur_word;
  logic [XLEN-1:0]       cur_pc;
  logic                  have_word;
  int                    sent;

  decode_unit dut_i (.*);

  decode_checker checker_i (.*);

  bind decode_unit decode_unit_asserts asserts_i (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // low bits of a power of two LCG repeat quickly
    return {8'h00, lcg_state[31:8]};
  endfunction

  // legal words of every class, plus an occasional raw random word
  function automatic logic [XLEN-1:0] make_inst();
    logic [31:0] sel;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    sel = lcg_next();
    hi = lcg_next();
    lo = lcg_next();
    // a small register range makes hazards and forwarding common
    rd = 5'(lo % 8);
    rs1 = 5'((lo >> 3) % 8);
    rs2 = 5'((lo >> 6) % 8);
    f3 = hi[22:20];
    case (sel % 10)
      0: return {hi[19:0], rd, 7'b0110111};
      1: return {hi[19:0], rd, 7'b0010111};
      2: return {hi[19:0], rd, 7'b1101111};
      3: return {hi[11:0], rs1, 3'b000, rd, 7'b1100111};
      4: begin
        if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
        return {hi[6:0], rs2, rs1, f3, hi[11:7], 7'b1100011};
      end
      5: return {hi[11:0], rs1, LOAD_F3[hi[23:20] % 5], rd, 7'b0000011};
      6: return {hi[11:5], rs2, rs1, 3'(hi[23:22] % 3), hi[4:0], 7'b0100011};
      7: begin
        if (f3 == 3'd1) f7 = 7'h00;
        else if (f3 == 3'd5) f7 = hi[23] ? 7'h20 : 7'h00;
        else f7 = lo[23:17];
        return {f7, hi[4:0], rs1, f3, rd, 7'b0010011};
      end
      8: begin
        f7 = (hi[23] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
      end
      default: return {hi[15:0], lo[23:8]};
    endcase
  endfunction

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // handshake seen before the edge, read by the stimulus at the edge
  always @(negedge clock) begin
    taken = inst_valid && ready && !block && !flush && !reset;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: no drain after %0d ns, %0d of %0d instructions sent",
             WATCHDOG_NS, sent, NUM_INST);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    reset = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    pc = '0;
    block = 1'b0;
    flush = 1'b0;
    lcg_state = 32'd68;
    sent = 0;
    have_word = 1'b0;
    cur_word = '0;
    cur_pc = 32'h0000_1000;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    while (sent < NUM_INST) begin
      @(posedge clock);
      if (taken) begin
        sent++;
        have_word = 1'b0;
      end
      // an unaccepted word is offered again, so a held consumer gets in later
      if (!have_word) begin
        cur_word = make_inst();
        cur_pc = cur_pc + 32'd4;
        have_word = 1'b1;
      end
      r = lcg_next();
      inst_valid <= r[1:0] != 2'b00;
      inst <= cur_word;
      pc <= cur_pc;
      block <= r[5:3] == 3'b000;
      flush <= r[10:6] == 5'b00000;
    end
    @(posedge clock);
    inst_valid <= 1'b0;
    block <= 1'b0;
    flush <= 1'b0;
    @(posedge clock);
    while (!idle) @(posedge clock);
    $display("decode checks %0d, mismatches %0d, assertion failures %0d",
             check_count, error_count, dut_i.asserts_i.fail_count);
    if (error_count == 0 && check_count > 0 && dut_i.asserts_i.fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
